/* list.f */
+incdir+common
common/exec_pkg.sv
common/muldiv_if.sv
alu/cla_32bit.sv
alu/alu.sv
muldiv/mul_unit.sv
muldiv/div_unit.sv
verilog/exec_unit.sv
tests/exec_unit_asserts.sv
tests/exec_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= exec_unit_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/exec_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module exec_unit_tb;
        import exec_pkg::*;

        localparam int n_rand = 8;
        localparam int n_ops  = 13 * n_rand + 12 + 3 * n_rand + 12 + 4 * n_rand + 8 + 4;
        localparam int limit  = n_ops * 40 + 100;  // Cycles before the watchdog fires
        localparam op_t alu_ops [13] = '{`OP_ADD, `OP_SUB, `OP_SLL, `OP_SLT, `OP_SLTU,
                `OP_XOR, `OP_SRL, `OP_SRA, `OP_OR, `OP_AND, `OP_XNOR, `OP_LUI, 4'b0010};
        localparam word_t signs_a [4] = '{32'h7FFF_1234, 32'h8000_0001, 32'h0001_F00D,
                32'hFFFF_FFFE};
        localparam word_t signs_b [4] = '{32'h0000_0D0E, 32'h0123_4567, 32'h8765_4321,
                32'hC000_0003};

        logic      clk;
        logic      rst_n;
        logic      start;
        word_t     alu1;
        word_t     alu2;
        op_t       alu_op;
        unit_sel_t chip_select;
        word_t     result;
        logic      done;
        logic      busy;
        int        errors;
        int        cycles;

        exec_unit exec_unit_inst (
                .clk_i         (clk),
                .rst_n_i       (rst_n),
                .start_i       (start),
                .alu1_i        (alu1),
                .alu2_i        (alu2),
                .alu_op_i      (alu_op),
                .chip_select_i (chip_select),
                .result_o      (result),
                .done_o        (done),
                .busy_o        (busy)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // Reference results straight from the ISA rules
        function automatic word_t expected(input unit_sel_t sel, input op_t op,
                                           input word_t a, input word_t b);
                logic signed [63:0] sp;
                logic [63:0]        up;
                word_t              res;

                res = '0;
                sp  = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                up  = {32'b0, a} * {32'b0, b};
                if (sel == `SEL_ALU) begin
                        case (op)
                                `OP_ADD:  res = a + b;
                                `OP_SUB:  res = a - b;
                                `OP_SLL:  res = a << b[4:0];
                                `OP_SLT:  res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
                                `OP_SLTU: res = {31'b0, a < b};
                                `OP_XOR:  res = a ^ b;
                                `OP_SRL:  res = a >> b[4:0];
                                `OP_SRA:  res = (a >> b[4:0])  // Sign fills the vacated bits
                                                | ({32{a[31]}} & ~(32'hFFFF_FFFF >> b[4:0]));
                                `OP_OR:   res = a | b;
                                `OP_AND:  res = a & b;
                                `OP_XNOR: res = ~(a ^ b);
                                `OP_LUI:  res = b;
                                default:  res = '0;
                        endcase
                end else if (sel == `SEL_MUL) begin
                        case (op)
                                `MD_MUL:   res = up[31:0];
                                `MD_MULH:  res = sp[63:32];
                                `MD_MULHU: res = up[63:32];
                                default:   res = '0;
                        endcase
                end else if (sel == `SEL_DIV) begin
                        if (b == '0)
                                res = (op == `MD_DIV || op == `MD_DIVU) ? 32'hFFFF_FFFF : a;
                        else if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF && op == `MD_DIV)
                                res = a;
                        else if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF && op == `MD_REM)
                                res = '0;
                        else begin
                                case (op)
                                        `MD_DIV:  res = $signed(a) / $signed(b);
                                        `MD_DIVU: res = a / b;
                                        `MD_REM:  res = $signed(a) % $signed(b);
                                        `MD_REMU: res = a % b;
                                        default:  res = '0;
                                endcase
                        end
                end
                return res;
        endfunction

        task automatic issue(input unit_sel_t sel, input op_t op, input word_t a, input word_t b);
                @(negedge clk);
                start       = 1'b1;
                chip_select = sel;
                alu_op      = op;
                alu1        = a;
                alu2        = b;
                @(negedge clk);
                start = 1'b0;
        endtask

        task automatic check_result(input string name, input word_t exp);
                assert (result == exp)
                else begin
                        errors++;
                        $display("MISMATCH %s expected %08h actual %08h", name, exp, result);
                end
        endtask

        task automatic run_op(input string name, input unit_sel_t sel, input op_t op,
                              input word_t a, input word_t b);
                word_t exp;

                exp = expected(sel, op, a, b);
                issue(sel, op, a, b);
                if (sel == `SEL_ALU) begin
                        assert (done)
                        else begin
                                errors++;
                                $display("%s: done_o did not follow start after one cycle", name);
                        end
                end
                while (!done)
                        @(negedge clk);
                check_result(name, exp);
        endtask

        // No completion may show up and the result must not move
        task automatic quiet_check(input string name, input int n, input word_t held);
                repeat (n) begin
                        assert (!done)
                        else begin
                                errors++;
                                $display("%s: unexpected done_o pulse", name);
                        end
                        check_result(name, held);
                        @(negedge clk);
                end
        endtask

        initial begin : watchdog
                cycles = 0;
                while (cycles < limit) begin
                        @(posedge clk);
                        cycles++;
                end
                $display("Timeout after %0d cycles, an operation never completed", cycles);
                $display("TB FAILED");
                $finish;
        end

        initial begin : stimulus
                word_t a;
                word_t b;
                word_t held;
                int    asrt_fails;

                errors      = 0;
                rst_n       = 1'b0;
                start       = 1'b0;
                alu1        = '0;
                alu2        = '0;
                alu_op      = '0;
                chip_select = '0;
                void'($urandom(32'he696));
                repeat (5) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;

                @(negedge clk);
                check_result("after reset", '0);
                assert (!done && !busy)
                else begin
                        errors++;
                        $display("done_o or busy_o high right after reset");
                end

                foreach (alu_ops[k]) begin
                        for (int i = 0; i < n_rand; i++) begin
                                run_op($sformatf("alu op %h #%0d", alu_ops[k], i), `SEL_ALU,
                                       alu_ops[k], $urandom(), $urandom());
                        end
                end
                run_op("slt neg vs pos", `SEL_ALU, `OP_SLT, 32'hFFFF_FFFF, 32'h1);
                run_op("sltu neg vs pos", `SEL_ALU, `OP_SLTU, 32'hFFFF_FFFF, 32'h1);
                run_op("slt pos vs neg", `SEL_ALU, `OP_SLT, 32'h1, 32'h8000_0000);
                run_op("sltu pos vs neg", `SEL_ALU, `OP_SLTU, 32'h1, 32'h8000_0000);
                foreach (alu_ops[k]) begin
                        if (alu_ops[k] == `OP_SLL || alu_ops[k] == `OP_SRL
                            || alu_ops[k] == `OP_SRA) begin
                                a = $urandom() | 32'h8000_0000;  // Top bit set for SRA
                                run_op("shift amount 37", `SEL_ALU, alu_ops[k], a, 32'h25);
                                run_op("shift amount wraps", `SEL_ALU, alu_ops[k], a,
                                       32'hFFFF_FFE3);
                        end
                end
                run_op("add overflow", `SEL_ALU, `OP_ADD, 32'h7FFF_FFFF, 32'h1);
                run_op("sub borrow", `SEL_ALU, `OP_SUB, 32'h0, 32'h1);

                for (int m = 0; m < 3; m++) begin
                        for (int i = 0; i < n_rand; i++) begin
                                run_op($sformatf("mul op %0d #%0d", m, i), `SEL_MUL, op_t'(m),
                                       $urandom(), $urandom());
                        end
                        foreach (signs_a[s]) begin
                                run_op($sformatf("mul op %0d signs %0d", m, s), `SEL_MUL,
                                       op_t'(m), signs_a[s], signs_b[s]);
                        end
                end

                for (int d = 3; d < 7; d++) begin
                        for (int i = 0; i < n_rand; i++) begin
                                b = $urandom() >> ($urandom() % 32);  // Mix of divisor sizes
                                run_op($sformatf("div op %0d #%0d", d, i), `SEL_DIV, op_t'(d),
                                       $urandom(), b);
                        end
                        run_op($sformatf("div op %0d by zero", d), `SEL_DIV, op_t'(d),
                               $urandom(), 32'h0);
                        run_op($sformatf("div op %0d min by -1", d), `SEL_DIV, op_t'(d),
                               32'h8000_0000, 32'hFFFF_FFFF);
                end

                a    = 32'h1234_5678;
                b    = 32'h0000_0ABC;
                held = expected(`SEL_MUL, `MD_MUL, a, b);
                issue(`SEL_MUL, `MD_MUL, a, b);
                assert (busy)
                else begin
                        errors++;
                        $display("busy_o did not rise after a multiply start");
                end
                issue(`SEL_ALU, `OP_ADD, 32'h1, 32'h1);
                while (!done)
                        @(negedge clk);
                check_result("start during busy", held);
                @(negedge clk);
                quiet_check("after busy start", 3, held);
                issue(2'b11, `OP_ADD, a, b);
                quiet_check("select 11", 4, held);

                asrt_fails = int'(exec_unit_inst.u_asserts.fail_count);
                $display("Errors: %0d result checks, %0d protocol assertions",
                         errors, asrt_fails);
                if (errors == 0 && asrt_fails == 0)
                        $display("TB PASSED");
                else
                        $display("TB FAILED");
                $finish;
        end

endmodule

`default_nettype wire

/* tests/exec_unit_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit_asserts (
        input wire                  clk_i,
        input wire                  rst_n_i,
        input wire                  done_i,
        input wire                  busy_i,
        input wire exec_pkg::word_t result_i
);
        int unsigned fail_count = 0;  // Read by the testbench at the end

        done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                done_i |=> !done_i)
        else begin
                fail_count++;
                $error("done_o stayed high for more than one cycle");
        end

        // A unit may only release busy on its completion edge
        busy_falls_with_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                $fell(busy_i) |-> done_i)
        else begin
                fail_count++;
                $error("busy_o fell without done_o");
        end

        result_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                !done_i |-> $stable(result_i))
        else begin
                fail_count++;
                $error("result_o changed while done_o was low");
        end

endmodule

bind exec_unit exec_unit_asserts u_asserts (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .done_i   (done_o),
        .busy_i   (busy_o),
        .result_i (result_o)
);

`default_nettype wire

/* verilog/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module exec_unit (
        input  wire                      clk_i,
        input  wire                      rst_n_i,
        input  wire                      start_i,
        input  wire exec_pkg::word_t     alu1_i,
        input  wire exec_pkg::word_t     alu2_i,
        input  wire exec_pkg::op_t       alu_op_i,
        input  wire exec_pkg::unit_sel_t chip_select_i,
        output exec_pkg::word_t          result_o,
        output logic                     done_o,
        output logic                     busy_o
);
        import exec_pkg::*;

        word_t alu_result;
        logic  accept;
        logic  go_alu;
        logic  go_mul;
        logic  go_div;

        muldiv_if mul_bus ();
        muldiv_if div_bus ();

        assign accept = start_i & ~busy_o;  // Drop requests while a unit runs
        assign go_alu = accept & (chip_select_i == `SEL_ALU);
        assign go_mul = accept & (chip_select_i == `SEL_MUL);
        assign go_div = accept & (chip_select_i == `SEL_DIV);

        alu u_alu (
                .alu1_i   (alu1_i),
                .alu2_i   (alu2_i),
                .alu_op_i (alu_op_i),
                .result_o (alu_result)
        );

        assign mul_bus.start     = go_mul;
        assign mul_bus.op        = alu_op_i;
        assign mul_bus.operand_a = alu1_i;
        assign mul_bus.operand_b = alu2_i;

        assign div_bus.start     = go_div;
        assign div_bus.op        = alu_op_i;
        assign div_bus.operand_a = alu1_i;
        assign div_bus.operand_b = alu2_i;

        mul_unit u_mul (
                .clk_i   (clk_i),
                .rst_n_i (rst_n_i),
                .md      (mul_bus.unit)
        );

        div_unit u_div (
                .clk_i   (clk_i),
                .rst_n_i (rst_n_i),
                .md      (div_bus.unit)
        );

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        result_o <= '0;
                        done_o   <= 1'b0;
                        busy_o   <= 1'b0;
                end else begin
                        done_o <= go_alu | mul_bus.done | div_bus.done;
                        if (go_alu)
                                result_o <= alu_result;
                        else if (mul_bus.done)
                                result_o <= mul_bus.result;
                        else if (div_bus.done)
                                result_o <= div_bus.result;

                        // Busy falls on the edge that raises done_o
                        if (go_mul | go_div)
                                busy_o <= 1'b1;
                        else if (mul_bus.done | div_bus.done)
                                busy_o <= 1'b0;
                end
        end

endmodule

`default_nettype wire

/* muldiv/div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module div_unit (
        input  wire    clk_i,
        input  wire    rst_n_i,
        muldiv_if.unit md
);
        import exec_pkg::*;

        localparam word_t word_min = {1'b1, {(`EXEC_XLEN-1){1'b0}}};

        md_state_t           state;
        step_t               step;
        word_t               rem;
        word_t               quo;        // Dividend shifts out as quotient shifts in
        word_t               dvsr;
        word_t               mag_a;
        word_t               mag_b;
        word_t               q_fix;
        word_t               r_fix;
        logic [`EXEC_XLEN:0] diff;
        logic                signed_op;
        logic                sgn_a;
        logic                sgn_b;
        logic                q_neg;
        logic                r_neg;
        logic                want_rem;
        logic                div_zero;
        logic                ovf;

        assign signed_op = (md.op == `MD_DIV) || (md.op == `MD_REM);
        assign sgn_a     = signed_op & md.operand_a[`EXEC_XLEN-1];
        assign sgn_b     = signed_op & md.operand_b[`EXEC_XLEN-1];
        assign mag_a     = sgn_a ? -md.operand_a : md.operand_a;
        assign mag_b     = sgn_b ? -md.operand_b : md.operand_b;

        // Trial subtract, negative result means restore
        assign diff = {rem, quo[`EXEC_XLEN-1]} - {1'b0, dvsr};

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        state <= IDLE;
                        step  <= '0;
                end else begin
                        case (state)
                                IDLE: begin
                                        if (md.start) begin
                                                state <= RUN;
                                                step  <= '0;
                                        end
                                end
                                RUN: begin
                                        step <= step + 1'b1;
                                        if (step == step_t'(`EXEC_XLEN - 1))
                                                state <= FINISH;
                                end
                                default: begin
                                        state <= IDLE;
                                end
                        endcase
                end
        end

        always_ff @(posedge clk_i) begin
                if (state == IDLE && md.start) begin
                        rem      <= '0;
                        quo      <= mag_a;
                        dvsr     <= mag_b;
                        q_neg    <= sgn_a ^ sgn_b;
                        r_neg    <= sgn_a;                // Remainder follows dividend
                        want_rem <= (md.op == `MD_REM) || (md.op == `MD_REMU);
                        div_zero <= (md.operand_b == '0);
                        ovf      <= signed_op && (md.operand_a == word_min) && (&md.operand_b);
                end else if (state == RUN) begin
                        if (!diff[`EXEC_XLEN])
                                rem <= diff[`EXEC_XLEN-1:0];
                        else
                                rem <= {rem[`EXEC_XLEN-2:0], quo[`EXEC_XLEN-1]};
                        quo <= {quo[`EXEC_XLEN-2:0], !diff[`EXEC_XLEN]};
                end
        end

        assign q_fix = q_neg ? -quo : quo;
        assign r_fix = r_neg ? -rem : rem;

        always_comb begin
                if (want_rem)
                        md.result = ovf ? '0 : r_fix;  // Zero divisor leaves dividend here
                else if (div_zero)
                        md.result = '1;
                else if (ovf)
                        md.result = word_min;
                else
                        md.result = q_fix;
        end

        assign md.done = (state == FINISH);

endmodule

`default_nettype wire

/* muldiv/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module mul_unit (
        input  wire    clk_i,
        input  wire    rst_n_i,
        muldiv_if.unit md
);
        import exec_pkg::*;

        md_state_t           state;
        step_t               step;
        dword_t              prod;       // Upper half sums, lower half holds multiplier
        dword_t              prod_fix;
        word_t               mcand;
        word_t               mag_a;
        word_t               mag_b;
        logic [`EXEC_XLEN:0] sum;
        logic                signed_op;
        logic                sgn_a;
        logic                sgn_b;
        logic                neg;
        logic                high;       // Return upper product word

        assign signed_op = (md.op == `MD_MULH);
        assign sgn_a     = signed_op & md.operand_a[`EXEC_XLEN-1];
        assign sgn_b     = signed_op & md.operand_b[`EXEC_XLEN-1];
        assign mag_a     = sgn_a ? -md.operand_a : md.operand_a;
        assign mag_b     = sgn_b ? -md.operand_b : md.operand_b;

        assign sum = {1'b0, prod[2*`EXEC_XLEN-1:`EXEC_XLEN]}
                   + (prod[0] ? {1'b0, mcand} : '0);

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        state <= IDLE;
                        step  <= '0;
                end else begin
                        case (state)
                                IDLE: begin
                                        if (md.start) begin
                                                state <= RUN;
                                                step  <= '0;
                                        end
                                end
                                RUN: begin
                                        step <= step + 1'b1;
                                        if (step == step_t'(`EXEC_XLEN - 1))
                                                state <= FINISH;
                                end
                                default: begin
                                        state <= IDLE;
                                end
                        endcase
                end
        end

        always_ff @(posedge clk_i) begin
                if (state == IDLE && md.start) begin
                        prod  <= {{`EXEC_XLEN{1'b0}}, mag_b};
                        mcand <= mag_a;
                        neg   <= sgn_a ^ sgn_b;
                        high  <= (md.op != `MD_MUL);
                end else if (state == RUN) begin
                        prod <= {sum, prod[`EXEC_XLEN-1:1]};  // Add then shift right
                end
        end

        assign prod_fix  = neg ? -prod : prod;
        assign md.result = high ? prod_fix[2*`EXEC_XLEN-1:`EXEC_XLEN]
                                : prod_fix[`EXEC_XLEN-1:0];
        assign md.done   = (state == FINISH);

endmodule

`default_nettype wire

/* alu/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module alu (
        input  wire exec_pkg::word_t alu1_i,
        input  wire exec_pkg::word_t alu2_i,
        input  wire exec_pkg::op_t   alu_op_i,
        output exec_pkg::word_t      result_o
);
        import exec_pkg::*;

        word_t      sum_result;
        logic       sum_carry;
        word_t      xor_result;
        logic [4:0] shamt;

        // Opcode bit 0 selects subtract, which covers SUB and SLTU
        cla_32bit u_cla32 (
                .term1_i  (alu1_i),
                .term2_i  (alu2_i),
                .carry_i  (alu_op_i[0]),
                .result_o (sum_result),
                .carry_o  (sum_carry)
        );

        assign xor_result = alu1_i ^ alu2_i;
        assign shamt      = alu2_i[4:0];    // Upper bits ignored

        always_comb begin
                case (alu_op_i)
                        `OP_ADD,
                        `OP_SUB: begin
                                result_o = sum_result;
                        end
                        `OP_SLL: begin
                                result_o = alu1_i << shamt;
                        end
                        `OP_SLT: begin
                                result_o = word_t'($signed(alu1_i) < $signed(alu2_i));
                        end
                        `OP_SLTU: begin
                                result_o = word_t'(!sum_carry);  // Borrow out
                        end
                        `OP_XOR: begin
                                result_o = xor_result;
                        end
                        `OP_SRL: begin
                                result_o = alu1_i >> shamt;
                        end
                        `OP_SRA: begin
                                result_o = word_t'($signed(alu1_i) >>> shamt);
                        end
                        `OP_OR: begin
                                result_o = alu1_i | alu2_i;
                        end
                        `OP_AND: begin
                                result_o = alu1_i & alu2_i;
                        end
                        `OP_XNOR: begin
                                result_o = ~xor_result;
                        end
                        `OP_LUI: begin
                                result_o = alu2_i;  // Immediate already shifted
                        end
                        default: begin
                                result_o = '0;      // 0010 and 1101..1111
                        end
                endcase
        end

endmodule

`default_nettype wire

/* alu/cla_32bit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module cla_32bit (
        input  wire exec_pkg::word_t term1_i,
        input  wire exec_pkg::word_t term2_i,
        input  wire                  carry_i,
        output exec_pkg::word_t      result_o,
        output logic                 carry_o
);
        import exec_pkg::*;

        word_t      b_eff;
        word_t      g;
        word_t      p;
        word_t      c;
        logic [7:0] grp_g;
        logic [7:0] grp_p;
        logic [8:0] grp_c;

        assign b_eff = term2_i ^ {`EXEC_XLEN{carry_i}};  // Inverted for subtract
        assign g     = term1_i & b_eff;
        assign p     = term1_i ^ b_eff;

        for (genvar gi = 0; gi < 8; gi++) begin : g_grp
                localparam int base = 4 * gi;

                assign c[base]     = grp_c[gi];
                assign c[base + 1] = g[base] | (p[base] & grp_c[gi]);
                assign c[base + 2] = g[base + 1] | (p[base + 1] & g[base])
                                   | (p[base + 1] & p[base] & grp_c[gi]);
                assign c[base + 3] = g[base + 2] | (p[base + 2] & g[base + 1])
                                   | (p[base + 2] & p[base + 1] & g[base])
                                   | (p[base + 2] & p[base + 1] & p[base] & grp_c[gi]);

                assign grp_g[gi] = g[base + 3] | (p[base + 3] & g[base + 2])
                                 | (p[base + 3] & p[base + 2] & g[base + 1])
                                 | (p[base + 3] & p[base + 2] & p[base + 1] & g[base]);
                assign grp_p[gi] = &p[base +: 4];
        end

        // Second level, each group carry from all lower group terms at once
        always_comb begin
                logic run_p;

                grp_c[0] = carry_i;
                for (int j = 1; j <= 8; j++) begin
                        grp_c[j] = 1'b0;
                        run_p    = 1'b1;
                        for (int k = j - 1; k >= 0; k--) begin
                                grp_c[j] = grp_c[j] | (run_p & grp_g[k]);
                                run_p    = run_p & grp_p[k];
                        end
                        grp_c[j] = grp_c[j] | (run_p & carry_i);
                end
        end

        assign result_o = p ^ c;
        assign carry_o  = grp_c[8];

endmodule

`default_nettype wire

/* common/muldiv_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface muldiv_if;
        import exec_pkg::*;

        logic  start;        // One-cycle request
        op_t   op;
        word_t operand_a;
        word_t operand_b;
        word_t result;       // Valid while done is high
        logic  done;         // One-cycle completion

        modport master (
                output start, op, operand_a, operand_b,
                input  result, done
        );

        modport unit (
                input  start, op, operand_a, operand_b,
                output result, done
        );

endinterface

`default_nettype wire

/* common/exec_pkg.sv */
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

        typedef logic [`EXEC_XLEN-1:0]   word_t;    // One data word
        typedef logic [2*`EXEC_XLEN-1:0] dword_t;   // Full product
        typedef logic [3:0]              op_t;
        typedef logic [1:0]              unit_sel_t;
        typedef logic [5:0]              step_t;    // Iteration count

        // Sequencer shared by the multiplier and the divider
        typedef enum logic [1:0] {
                IDLE,
                RUN,
                FINISH
        } md_state_t;

endpackage

`default_nettype wire

/* common/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

`define EXEC_XLEN 32

// ALU opcodes, unit select 00
`define OP_ADD  4'b0000
`define OP_SUB  4'b0001
`define OP_SLL  4'b0011
`define OP_SLT  4'b0100
`define OP_SLTU 4'b0101
`define OP_XOR  4'b0110
`define OP_SRL  4'b0111
`define OP_SRA  4'b1000
`define OP_OR   4'b1001
`define OP_AND  4'b1010
`define OP_XNOR 4'b1011
`define OP_LUI  4'b1100

// Multiply and divide opcodes share the same field
`define MD_MUL   4'd0
`define MD_MULH  4'd1
`define MD_MULHU 4'd2
`define MD_DIV   4'd3
`define MD_DIVU  4'd4
`define MD_REM   4'd5
`define MD_REMU  4'd6

`define SEL_ALU 2'b00
`define SEL_MUL 2'b01
`define SEL_DIV 2'b10

`endif
